/* common/aluPkg.sv */
package aluPkg;

    localparam int XLEN = 64; // one machine word

    // operations the execute stage knows
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10 // lui
    } aluOp_e;

endpackage

/* common/rvPkg.sv */
package rvPkg;

    localparam int REG_ADDR_W = 5; // x0..x31

    // major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_32     = 7'b0111011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111
    } opcode_e;

    // funct3 field, bits [14:12]
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 field, bits [31:25]
    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20; // sub / sra variants

    // result width seen by writeback
    typedef enum logic {
        FMT_FULL = 1'b0,
        FMT_WORD = 1'b1 // sign-extend bit 31
    } resFmt_e;

endpackage

/* decode/immGen.sv */
`timescale 1ns/1ps

module immGen
    import aluPkg::*, rvPkg::*;
(
    input  logic [31:0]     inInst,
    output logic [XLEN-1:0] imm
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic            isShift;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immU;

    assign opcode  = opcode_e'(inInst[6:0]);
    assign funct3  = inInst[14:12];
    assign isShift = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);

    assign immI = {{(XLEN-12){inInst[31]}}, inInst[31:20]};
    assign immU = {{(XLEN-32){inInst[31]}}, inInst[31:12], 12'b0};

    always_comb begin
        case (opcode)
            OPC_OP_IMM: begin
                if (isShift) begin
                    imm = {{(XLEN-6){1'b0}}, inInst[25:20]}; // 6-bit shamt
                end else begin
                    imm = immI;
                end
            end
            OPC_OP_IMM_32: begin
                if (isShift) begin
                    imm = {{(XLEN-5){1'b0}}, inInst[24:20]}; // word shamt
                end else begin
                    imm = immI;
                end
            end
            OPC_LUI,
            OPC_AUIPC: imm = immU;
            default:   imm = '0;
        endcase
    end

endmodule

/* decode/instDecoder.sv */
`timescale 1ns/1ps

module instDecoder
    import aluPkg::*, rvPkg::*;
(
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inValid,
    output logic                  inReady,
    input  logic [31:0]           inInst,
    input  logic [XLEN-1:0]       inPc,
    output logic [REG_ADDR_W-1:0] rdAddr1,
    output logic [REG_ADDR_W-1:0] rdAddr2,
    input  logic [XLEN-1:0]       rdData1,
    input  logic [XLEN-1:0]       rdData2,
    input  logic                  exBusy,
    input  logic [REG_ADDR_W-1:0] exRd,
    input  logic                  exWrite,
    input  logic                  rbBusy,
    input  logic [REG_ADDR_W-1:0] rbRd,
    input  logic                  rbWrite,
    output logic                  decValid,
    input  logic                  decReady,
    output aluOp_e                decOp,
    output logic [XLEN-1:0]       decA,
    output logic [XLEN-1:0]       decB,
    output resFmt_e               decFmt,
    output logic [REG_ADDR_W-1:0] decRd,
    output logic                  decWrite,
    output logic                  decIllegal
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic                  regForm;
    logic                  wordForm;
    logic                  f7Base;
    logic                  f7Alt;
    aluOp_e                op;
    resFmt_e               fmt;
    logic                  legal;
    logic                  useRs1;
    logic                  useRs2;
    logic                  usePc;
    logic [XLEN-1:0]       opA;
    logic [XLEN-1:0]       opB;
    logic                  rs1Hit;
    logic                  rs2Hit;
    logic                  hazard;
    logic                  loadDec;

    assign opcode  = opcode_e'(inInst[6:0]);
    assign funct3  = inInst[14:12];
    assign funct7  = inInst[31:25];
    assign rd      = inInst[11:7];
    assign rdAddr1 = inInst[19:15];
    assign rdAddr2 = inInst[24:20];

    assign regForm  = (opcode == OPC_OP) || (opcode == OPC_OP_32);
    assign wordForm = (opcode == OPC_OP_32) || (opcode == OPC_OP_IMM_32);
    // 64-bit immediate shifts give bit 25 to the shift amount
    assign f7Base = (opcode == OPC_OP_IMM) ? (funct7[6:1] == F7_BASE[6:1]) : (funct7 == F7_BASE);
    assign f7Alt  = (opcode == OPC_OP_IMM) ? (funct7[6:1] == F7_ALT[6:1]) : (funct7 == F7_ALT);

    immGen immGenI (
        .inInst (inInst),
        .imm    (imm)
    );

    always_comb begin
        op     = ALU_ADD;
        fmt    = wordForm ? FMT_WORD : FMT_FULL;
        legal  = 1'b0;
        useRs1 = 1'b0;
        useRs2 = 1'b0;
        usePc  = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32: begin
                useRs1 = 1'b1;
                useRs2 = regForm;
                case (funct3)
                    F3_ADD_SUB: begin
                        op    = (regForm && f7Alt) ? ALU_SUB : ALU_ADD;
                        legal = !regForm || f7Base || f7Alt;
                    end
                    F3_SLL: begin
                        op    = ALU_SLL;
                        legal = f7Base;
                    end
                    F3_SRL_SRA: begin
                        op    = f7Alt ? ALU_SRA : ALU_SRL;
                        legal = f7Base || f7Alt;
                    end
                    F3_SLT:  op = ALU_SLT;
                    F3_SLTU: op = ALU_SLTU;
                    F3_XOR:  op = ALU_XOR;
                    F3_OR:   op = ALU_OR;
                    F3_AND:  op = ALU_AND;
                    default: op = ALU_ADD;
                endcase
                // logic and compare forms have no word variant
                if (funct3 == F3_SLT || funct3 == F3_SLTU || funct3 == F3_XOR ||
                    funct3 == F3_OR || funct3 == F3_AND) begin
                    legal = !wordForm && (!regForm || f7Base);
                end
            end
            OPC_LUI: begin
                op    = ALU_PASS_B;
                legal = 1'b1;
            end
            OPC_AUIPC: begin
                usePc = 1'b1;
                legal = 1'b1;
            end
            default: legal = 1'b0; // unsupported encoding
        endcase
    end

    always_comb begin
        opA = usePc ? inPc : rdData1;
        if (wordForm && (op == ALU_SRL || op == ALU_SRA)) begin
            opA = {{(XLEN-32){op == ALU_SRA && rdData1[31]}}, rdData1[31:0]}; // word right shifts
        end
    end

    assign opB = useRs2 ? rdData2 : imm;

    // any older instruction still owing a register write blocks the read
    assign rs1Hit = useRs1 && rdAddr1 != '0 &&
                    ((decValid && decWrite && decRd == rdAddr1) ||
                     (exBusy && exWrite && exRd == rdAddr1) ||
                     (rbBusy && rbWrite && rbRd == rdAddr1));
    assign rs2Hit = useRs2 && rdAddr2 != '0 &&
                    ((decValid && decWrite && decRd == rdAddr2) ||
                     (exBusy && exWrite && exRd == rdAddr2) ||
                     (rbBusy && rbWrite && rbRd == rdAddr2));
    assign hazard = rs1Hit || rs2Hit;

    assign inReady = (!decValid || decReady) && !hazard;
    assign loadDec = inValid && inReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decValid <= 1'b0;
        end else if (!decValid || decReady) begin
            decValid <= loadDec;
        end
    end

    always_ff @(posedge clk) begin
        if (loadDec) begin
            decOp      <= op;
            decA       <= opA;
            decB       <= opB;
            decFmt     <= fmt;
            decRd      <= rd;
            decWrite   <= legal && rd != '0;
            decIllegal <= !legal;
        end
    end

    decNoRiseOnHazard: assert property (@(posedge clk) disable iff (!arstN)
        inValid && hazard |=> !$rose(decValid));

endmodule

/* execute/intAlu.sv */
`timescale 1ns/1ps

module intAlu
    import aluPkg::*, rvPkg::*;
(
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  decValid,
    output logic                  decReady,
    input  aluOp_e                decOp,
    input  logic [XLEN-1:0]       decA,
    input  logic [XLEN-1:0]       decB,
    input  resFmt_e               decFmt,
    input  logic [REG_ADDR_W-1:0] decRd,
    input  logic                  decWrite,
    input  logic                  decIllegal,
    output logic                  exValid,
    input  logic                  exReady,
    output logic [XLEN-1:0]       exResult,
    output resFmt_e               exFmt,
    output logic [REG_ADDR_W-1:0] exRd,
    output logic                  exWrite,
    output logic                  exIllegal
);

    logic [5:0]      shamt;
    logic [XLEN-1:0] aluOut;
    logic            loadEx;

    // word shifts only look at 5 bits
    assign shamt = (decFmt == FMT_WORD) ? {1'b0, decB[4:0]} : decB[5:0];

    always_comb begin
        case (decOp)
            ALU_ADD:    aluOut = decA + decB;
            ALU_SUB:    aluOut = decA - decB;
            ALU_SLL:    aluOut = decA << shamt;
            ALU_SLT:    aluOut = {{(XLEN-1){1'b0}}, $signed(decA) < $signed(decB)};
            ALU_SLTU:   aluOut = {{(XLEN-1){1'b0}}, decA < decB};
            ALU_XOR:    aluOut = decA ^ decB;
            ALU_SRL:    aluOut = decA >> shamt;
            ALU_SRA:    aluOut = $signed(decA) >>> shamt;
            ALU_OR:     aluOut = decA | decB;
            ALU_AND:    aluOut = decA & decB;
            ALU_PASS_B: aluOut = decB;
            default:    aluOut = '0;
        endcase
    end

    assign decReady = !exValid || exReady;
    assign loadEx   = decValid && decReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exValid <= 1'b0;
        end else if (decReady) begin
            exValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (loadEx) begin
            exResult  <= aluOut;
            exFmt     <= decFmt;
            exRd      <= decRd;
            exWrite   <= decWrite;
            exIllegal <= decIllegal;
        end
    end

    exHoldWhileStalled: assert property (@(posedge clk) disable iff (!arstN)
        exValid && !exReady |=> exValid && $stable(exResult) && $stable(exRd) &&
                                $stable(exWrite) && $stable(exIllegal));

endmodule

/* result/writeBack.sv */
`timescale 1ns/1ps

module writeBack
    import aluPkg::*, rvPkg::*;
(
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  exValid,
    output logic                  exReady,
    input  logic [XLEN-1:0]       exResult,
    input  resFmt_e               exFmt,
    input  logic [REG_ADDR_W-1:0] exRd,
    input  logic                  exWrite,
    input  logic                  exIllegal,
    output logic                  resValid,
    input  logic                  resReady,
    output logic [XLEN-1:0]       resData,
    output logic [REG_ADDR_W-1:0] resRd,
    output logic                  resWrite,
    output logic                  resIllegal,
    output logic                  wrEn,
    output logic [REG_ADDR_W-1:0] wrAddr,
    output logic [XLEN-1:0]       wrData
);

    assign exReady = !resValid || resReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resValid <= 1'b0;
        end else if (exReady) begin
            resValid <= exValid;
        end
    end

    always_ff @(posedge clk) begin
        if (exValid && exReady) begin
            resData    <= (exFmt == FMT_WORD) ?
                          {{(XLEN-32){exResult[31]}}, exResult[31:0]} : exResult;
            resRd      <= exRd;
            resWrite   <= exWrite && !exIllegal && exRd != '0; // x0 never written
            resIllegal <= exIllegal;
        end
    end

    assign wrEn   = resValid && resReady && resWrite; // write on output transfer
    assign wrAddr = resRd;
    assign wrData = resData;

    resHoldUntilTaken: assert property (@(posedge clk) disable iff (!arstN)
        resValid && !resReady |=> resValid && $stable(resData) && $stable(resRd));

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile
    import aluPkg::*, rvPkg::*;
(
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [REG_ADDR_W-1:0] rdAddr1,
    input  logic [REG_ADDR_W-1:0] rdAddr2,
    output logic [XLEN-1:0]       rdData1,
    output logic [XLEN-1:0]       rdData2,
    input  logic                  wrEn,
    input  logic [REG_ADDR_W-1:0] wrAddr,
    input  logic [XLEN-1:0]       wrData
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0; // whole file starts at zero
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // x0 reads zero regardless of storage
    assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

endmodule

/* logic/execCore.sv */
`timescale 1ns/1ps

module execCore
    import aluPkg::*, rvPkg::*;
(
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inValid,
    output logic                  inReady,
    input  logic [31:0]           inInst,
    input  logic [XLEN-1:0]       inPc,
    output logic                  resValid,
    input  logic                  resReady,
    output logic [XLEN-1:0]       resData,
    output logic [REG_ADDR_W-1:0] resRd,
    output logic                  resWrite,
    output logic                  resIllegal
);

    logic [REG_ADDR_W-1:0] rdAddr1;
    logic [REG_ADDR_W-1:0] rdAddr2;
    logic [XLEN-1:0]       rdData1;
    logic [XLEN-1:0]       rdData2;
    logic                  wrEn;
    logic [REG_ADDR_W-1:0] wrAddr;
    logic [XLEN-1:0]       wrData;

    logic                  decValid;
    logic                  decReady;
    aluOp_e                decOp;
    logic [XLEN-1:0]       decA;
    logic [XLEN-1:0]       decB;
    resFmt_e               decFmt;
    logic [REG_ADDR_W-1:0] decRd;
    logic                  decWrite;
    logic                  decIllegal;

    logic                  exValid;
    logic                  exReady;
    logic [XLEN-1:0]       exResult;
    resFmt_e               exFmt;
    logic [REG_ADDR_W-1:0] exRd;
    logic                  exWrite;
    logic                  exIllegal;

    regFile regFileI (
        .clk     (clk),
        .arstN   (arstN),
        .rdAddr1 (rdAddr1),
        .rdAddr2 (rdAddr2),
        .rdData1 (rdData1),
        .rdData2 (rdData2),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData)
    );

    instDecoder decoderI (
        .clk        (clk),
        .arstN      (arstN),
        .inValid    (inValid),
        .inReady    (inReady),
        .inInst     (inInst),
        .inPc       (inPc),
        .rdAddr1    (rdAddr1),
        .rdAddr2    (rdAddr2),
        .rdData1    (rdData1),
        .rdData2    (rdData2),
        .exBusy     (exValid),
        .exRd       (exRd),
        .exWrite    (exWrite),
        .rbBusy     (resValid), // result stage occupancy
        .rbRd       (resRd),
        .rbWrite    (resWrite),
        .decValid   (decValid),
        .decReady   (decReady),
        .decOp      (decOp),
        .decA       (decA),
        .decB       (decB),
        .decFmt     (decFmt),
        .decRd      (decRd),
        .decWrite   (decWrite),
        .decIllegal (decIllegal)
    );

    intAlu aluI (
        .clk        (clk),
        .arstN      (arstN),
        .decValid   (decValid),
        .decReady   (decReady),
        .decOp      (decOp),
        .decA       (decA),
        .decB       (decB),
        .decFmt     (decFmt),
        .decRd      (decRd),
        .decWrite   (decWrite),
        .decIllegal (decIllegal),
        .exValid    (exValid),
        .exReady    (exReady),
        .exResult   (exResult),
        .exFmt      (exFmt),
        .exRd       (exRd),
        .exWrite    (exWrite),
        .exIllegal  (exIllegal)
    );

    writeBack writeBackI (
        .clk        (clk),
        .arstN      (arstN),
        .exValid    (exValid),
        .exReady    (exReady),
        .exResult   (exResult),
        .exFmt      (exFmt),
        .exRd       (exRd),
        .exWrite    (exWrite),
        .exIllegal  (exIllegal),
        .resValid   (resValid),
        .resReady   (resReady),
        .resData    (resData),
        .resRd      (resRd),
        .resWrite   (resWrite),
        .resIllegal (resIllegal),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData)
    );

endmodule

/* verification/refModel.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// one expected output transfer
typedef struct packed {
    logic [63:0] data;
    logic [4:0]  rd;
    logic        wr;
    logic        ill;
} expEntry_t;

// expected outcome of one instruction, given the model values of rs1 and rs2
function automatic expEntry_t predictResult(input logic [31:0] inst, input logic [63:0] pc,
                                            input logic [63:0] a, input logic [63:0] b);
    expEntry_t   e;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [63:0] immI;
    logic [63:0] immU;
    logic [63:0] x;
    logic [31:0] w;
    logic [5:0]  sh;
    logic        regForm;
    logic        word;
    logic        sub;
    logic        ok;
    opc     = inst[6:0];
    f3      = inst[14:12];
    f7      = inst[31:25];
    immI    = {{52{inst[31]}}, inst[31:20]};
    immU    = {{32{inst[31]}}, inst[31:12], 12'h000};
    regForm = (opc == OPC_OP) || (opc == OPC_OP_32);
    word    = (opc == OPC_OP_32) || (opc == OPC_OP_IMM_32);
    x       = regForm ? b : immI;
    sh      = word ? {1'b0, x[4:0]} : x[5:0];
    sub     = regForm && f7 == F7_ALT;
    ok      = 1'b1;
    e.data  = '0;
    case (opc)
        OPC_LUI:   e.data = immU;
        OPC_AUIPC: e.data = pc + immU; // pc relative upper immediate
        OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32: begin
            case (f3)
                F3_ADD_SUB: ok = !regForm || f7 == F7_BASE || f7 == F7_ALT;
                F3_SLL:     ok = (opc == OPC_OP_IMM) ? inst[31:26] == 6'd0 : f7 == F7_BASE;
                F3_SRL_SRA: ok = (opc == OPC_OP_IMM) ?
                                 (inst[31:26] == 6'd0 || inst[31:26] == 6'b010000) :
                                 (f7 == F7_BASE || f7 == F7_ALT);
                default:    ok = !word && (!regForm || f7 == F7_BASE); // no word logic ops
            endcase
            if (word) begin
                case (f3)
                    F3_SLL:     w = a[31:0] << sh;
                    F3_SRL_SRA: if (inst[30]) w = $signed(a[31:0]) >>> sh;
                                else w = a[31:0] >> sh;
                    default:    w = sub ? a[31:0] - x[31:0] : a[31:0] + x[31:0];
                endcase
                e.data = {{32{w[31]}}, w};
            end else begin
                case (f3)
                    F3_ADD_SUB: e.data = sub ? a - x : a + x;
                    F3_SLL:     e.data = a << sh;
                    F3_SLT:     e.data = {63'd0, $signed(a) < $signed(x)};
                    F3_SLTU:    e.data = {63'd0, a < x};
                    F3_XOR:     e.data = a ^ x;
                    F3_SRL_SRA: if (inst[30]) e.data = $signed(a) >>> sh;
                                else e.data = a >> sh;
                    F3_OR:      e.data = a | x;
                    default:    e.data = a & x;
                endcase
            end
        end
        default: ok = 1'b0; // outside the supported set
    endcase
    e.rd  = inst[11:7];
    e.ill = !ok;
    e.wr  = ok && inst[11:7] != 5'd0;
    return e;
endfunction

`endif

/* verification/coreTb.sv */
`timescale 1ns/1ps

module coreTb
    import aluPkg::*, rvPkg::*;
();

    localparam int RST_CYCLES  = 10;
    localparam int FULL_COUNT  = 200;
    localparam int BP_COUNT    = 300;
    localparam int CYCLE_LIMIT = 4 * (FULL_COUNT + BP_COUNT) + RST_CYCLES;
    localparam int POOL_TOP    = 7; // x0..x7 only, keeps dependencies frequent

    `include "refModel.svh"

    logic                  clk;
    logic                  arstN;
    logic                  inValid;
    logic                  inReady;
    logic [31:0]           inInst;
    logic [XLEN-1:0]       inPc;
    logic                  resValid;
    logic                  resReady;
    logic [XLEN-1:0]       resData;
    logic [REG_ADDR_W-1:0] resRd;
    logic                  resWrite;
    logic                  resIllegal;

    logic [XLEN-1:0] modelRegs [32];
    expEntry_t       expQ [$];
    logic            backPressure;
    int              checkCount;
    int              errCount;
    int              testCount;
    int              cycleCount;

    execCore dut_i (
        .clk        (clk),
        .arstN      (arstN),
        .inValid    (inValid),
        .inReady    (inReady),
        .inInst     (inInst),
        .inPc       (inPc),
        .resValid   (resValid),
        .resReady   (resReady),
        .resData    (resData),
        .resRd      (resRd),
        .resWrite   (resWrite),
        .resIllegal (resIllegal)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (backPressure) begin
            resReady <= ($urandom_range(0, 3) != 0); // ready three cycles in four
        end else begin
            resReady <= 1'b1;
        end
    end

    // model runs in program order at input transfer
    always @(posedge clk) begin : acceptMon
        expEntry_t e;
        if (arstN && inValid && inReady) begin
            e = predictResult(inInst, inPc, modelRegs[inInst[19:15]], modelRegs[inInst[24:20]]);
            if (e.wr) begin
                modelRegs[e.rd] = e.data;
            end
            expQ.push_back(e);
        end
    end

    always @(posedge clk) begin : compareMon
        expEntry_t e;
        if (arstN && resValid && resReady) begin
            assert (expQ.size() != 0) else begin
                errCount++;
                $display("result for x%0d came out with no instruction outstanding", resRd);
            end
            if (expQ.size() != 0) begin
                e = expQ.pop_front();
                checkCount++;
                assert (resIllegal === e.ill) else begin
                    errCount++;
                    $display("ERR resIllegal got %h exp %h", resIllegal, e.ill);
                end
                assert (resRd === e.rd) else begin
                    errCount++;
                    $display("ERR resRd got %h exp %h", resRd, e.rd);
                end
                assert (resWrite === e.wr) else begin
                    errCount++;
                    $display("ERR resWrite got %h exp %h", resWrite, e.wr);
                end
                if (!e.ill) begin
                    assert (resData === e.data) else begin
                        errCount++;
                        $display("ERR resData got %h exp %h", resData, e.data);
                    end
                end
            end
        end
    end

    function automatic logic [31:0] randomInst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          kind;
        rd   = $urandom_range(0, POOL_TOP);
        rs1  = $urandom_range(0, POOL_TOP);
        rs2  = $urandom_range(0, POOL_TOP);
        f3   = $urandom_range(0, 7);
        imm  = $urandom;
        kind = $urandom_range(0, 19);
        f7   = (($urandom_range(0, 1) != 0) && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)) ?
               F7_ALT : F7_BASE;
        if (kind < 5) begin
            return {f7, rs2, rs1, f3, rd, OPC_OP};
        end
        if (kind < 10) begin
            if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                imm[11:6] = {1'b0, f7 == F7_ALT, 4'b0000}; // 6-bit shamt below
            end
            return {imm, rs1, f3, rd, OPC_OP_IMM};
        end
        if (kind < 16) begin
            f3 = (f3 < 3) ? F3_ADD_SUB : ((f3 < 5) ? F3_SLL : F3_SRL_SRA);
            f7 = (f3 != F3_SLL && $urandom_range(0, 1) != 0) ? F7_ALT : F7_BASE;
            if (kind < 13) begin
                return {f7, rs2, rs1, f3, rd, OPC_OP_32};
            end
            if (f3 != F3_ADD_SUB) begin
                imm = {f7, imm[4:0]};
            end
            return {imm, rs1, f3, rd, OPC_OP_IMM_32};
        end
        if (kind == 16) begin
            return {imm, rs1, f3, rd, OPC_LUI};
        end
        if (kind == 17) begin
            return {imm, rs1, f3, rd, OPC_AUIPC};
        end
        if (kind == 18) begin
            return {7'h01, rs2, rs1, f3, rd, OPC_OP}; // multiply group, not supported
        end
        return $urandom;
    endfunction

    task automatic sendInst(input logic [31:0] inst);
        logic [XLEN-1:0] pc;
        pc      = {$urandom, $urandom};
        pc[1:0] = 2'b00;
        inValid <= 1'b1;
        inInst  <= inst;
        inPc    <= pc;
        @(posedge clk);
        while (!inReady) begin
            @(posedge clk);
        end
    endtask

    task automatic finishTest(input string name, input int checksBefore, input int errsBefore);
        testCount++;
        $display("test %s: %0d checks, %0d errors", name, checkCount - checksBefore,
                 errCount - errsBefore);
    endtask

    task automatic runPhase(input string name, input logic pressure, input int count);
        int checksBefore;
        int errsBefore;
        checksBefore = checkCount;
        errsBefore   = errCount;
        backPressure <= pressure;
        for (int i = 0; i < count; i++) begin
            sendInst(randomInst());
        end
        inValid <= 1'b0;
        while (expQ.size() != 0) begin
            @(negedge clk); // drain
        end
        @(posedge clk);
        finishTest(name, checksBefore, errsBefore);
    endtask

    task automatic checkRegState();
        int errsBefore;
        int checksBefore;
        checksBefore = checkCount;
        errsBefore   = errCount;
        for (int i = 0; i < 32; i++) begin
            checkCount++;
            assert (dut_i.regFileI.regs[i] === modelRegs[i]) else begin
                errCount++;
                $display("ERR regFile x%0d got %h exp %h", i, dut_i.regFileI.regs[i],
                         modelRegs[i]);
            end
        end
        finishTest("register state", checksBefore, errsBefore);
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h5dd05f59));
        arstN        = 1'b0;
        inValid      = 1'b0;
        inInst       = '0;
        inPc         = '0;
        resReady     = 1'b0;
        backPressure = 1'b0;
        checkCount   = 0;
        errCount     = 0;
        testCount    = 0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        checkCount++;
        assert (resValid === 1'b0) else begin
            errCount++;
            $display("ERR resValid got %h exp %h", resValid, 1'b0);
        end
        checkCount++;
        assert (inReady === 1'b1) else begin
            errCount++;
            $display("ERR inReady got %h exp %h", inReady, 1'b1);
        end
        finishTest("reset state", 0, 0);
        runPhase("full throughput", 1'b0, FULL_COUNT);
        runPhase("random back-pressure", 1'b1, BP_COUNT);
        checkRegState();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+verification
common/aluPkg.sv
common/rvPkg.sv
decode/immGen.sv
decode/instDecoder.sv
execute/intAlu.sv
result/writeBack.sv
logic/regFile.sv
logic/execCore.sv
verification/coreTb.sv
